/* common/nnPkg.sv */
package nnPkg;

	localparam int NumInputs = 15;
	localparam int NumNodes = 4;
	localparam int PipeDepth = 3; // input pulse to valid node output

	typedef logic signed [7:0] actT;
	typedef logic [NumInputs*8-1:0] actVecT; // activation 0 in low byte
	typedef logic signed [7:0] weightT;
	typedef logic signed [15:0] biasT;
	typedef logic signed [22:0] accT;
	typedef logic [NumNodes*8-1:0] resultVecT; // node 0 in low byte
	typedef logic [7:0] axiAddrT;
	typedef logic [31:0] axiDataT;
	typedef logic [1:0] axiRespT;

	// fixed weights, one row per node
	localparam weightT WeightTable [NumNodes][NumInputs] = '{
		'{12, -7, 19, -25, 3, 30, -14, 8, -2, 22, -19, 6, 27, -11, 15},
		'{31, 28, 8, 31, 21, 11, -2, 25, -31, -18, 5, 5, -13, -31, 21},
		'{-18, 9, -30, 4, 26, -5, 13, -21, 17, 1, -9, 29, -3, 24, -16},
		'{7, 21, -12, 16, -28, -8, 31, 2, -23, 10, 18, -4, 14, -27, 5}
	};

	localparam biasT BiasTable [NumNodes] = '{
		16'sd512,
		-16'sd1024,
		16'sd256,
		-16'sd300
	};

	// register map, byte addresses
	localparam axiAddrT ActBase = 8'h00; // activation i at ActBase + 4*i
	localparam axiAddrT CtrlAddr = 8'h40;
	localparam axiAddrT StatusAddr = 8'h44;
	localparam axiAddrT ResultAddr = 8'h48;

	localparam axiRespT RespOkay = 2'd0;
	localparam axiRespT RespSlvErr = 2'd2;

endpackage

/* layer/neuronNode.sv */
`timescale 1ns/1ps

module neuronNode #(
	parameter int NodeIndex = 0
) (
	input logic clk,
	input logic reset,
	input nnPkg::actVecT activations,
	output nnPkg::actT out
);

	nnPkg::actT inReg [nnPkg::NumInputs];
	nnPkg::accT sumComb;
	nnPkg::accT sumReg;
	logic roundUp;
	logic overflow;

	// bias plus fifteen signed products
	always_comb
	begin
		sumComb = nnPkg::accT'(nnPkg::BiasTable[NodeIndex]);
		for (int i = 0; i < nnPkg::NumInputs; i++)
			sumComb = sumComb + inReg[i] * nnPkg::WeightTable[NodeIndex][i];
	end

	assign overflow = sumReg[21:13] != 9'd0;
	assign roundUp = sumReg[5] && sumReg[4:0] != 5'd0; // drop 6 fraction bits

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < nnPkg::NumInputs; i++)
				inReg[i] <= '0;
			sumReg <= '0;
			out <= '0;
		end
		else
		begin
			for (int i = 0; i < nnPkg::NumInputs; i++)
				inReg[i] <= activations[8*i +: 8];
			sumReg <= sumComb;

			// relu with saturation
			if (sumReg[22])
				out <= '0;
			else if (overflow)
				out <= 8'sd127;
			else if (roundUp)
				out <= sumReg[13:6] + 8'd1;
			else
				out <= sumReg[13:6];
		end
	end

endmodule

/* layer/denseLayer.sv */
`timescale 1ns/1ps

module denseLayer (
	input logic clk,
	input logic reset,
	input nnPkg::actVecT activations,
	input logic inValid,
	output nnPkg::resultVecT results,
	output logic resultValid,
	output logic busy
);

	nnPkg::actT nodeOut [nnPkg::NumNodes];
	logic [nnPkg::PipeDepth-1:0] validPipe;

	for (genvar g = 0; g < nnPkg::NumNodes; g++)
	begin : genNode
		neuronNode #(
			.NodeIndex(g)
		) i_node (
			.clk(clk),
			.reset(reset),
			.activations(activations),
			.out(nodeOut[g])
		);

		assign results[g*8 +: 8] = nodeOut[g];
	end

	// tracks items through the fixed neuron latency
	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[nnPkg::PipeDepth-2:0], inValid};
	end

	assign resultValid = validPipe[nnPkg::PipeDepth-1];
	assign busy = |validPipe; // anything in flight

endmodule

/* axiFront/axiRegFile.sv */
`timescale 1ns/1ps

module axiRegFile (
	input logic clk,
	input logic reset,
	input nnPkg::axiAddrT awaddr,
	input logic awvalid,
	output logic awready,
	input nnPkg::axiDataT wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output nnPkg::axiRespT bresp,
	output logic bvalid,
	input logic bready,
	input nnPkg::axiAddrT araddr,
	input logic arvalid,
	output logic arready,
	output nnPkg::axiDataT rdata,
	output nnPkg::axiRespT rresp,
	output logic rvalid,
	input logic rready,
	output nnPkg::actVecT activations,
	output logic startPulse,
	input nnPkg::resultVecT results,
	input logic resultValid,
	input logic busy
);

	logic wrReady;
	logic wrFire;
	logic wrAct;
	logic wrCtrl;
	logic wrStart;
	logic [3:0] wrIdx;
	logic rdFire;
	logic [3:0] rdIdx;
	nnPkg::actT rdByte;
	nnPkg::axiDataT rdWord;
	logic rdOk;
	nnPkg::resultVecT resultReg;
	logic done;

	function automatic logic isAct(nnPkg::axiAddrT addr);
		return addr >= nnPkg::ActBase && addr < nnPkg::ActBase + 4 * nnPkg::NumInputs
			&& addr[1:0] == 2'b00;
	endfunction

	// aw and w are taken together, wstrb ignored
	assign awready = wrReady;
	assign wready = wrReady;
	assign wrFire = wrReady && awvalid && wvalid;
	assign wrAct = isAct(awaddr);
	assign wrCtrl = awaddr == nnPkg::CtrlAddr;
	assign wrStart = wrFire && wrCtrl && wdata[0];
	assign wrIdx = 4'((awaddr - nnPkg::ActBase) >> 2);

	assign rdFire = arready && arvalid;
	assign rdIdx = 4'((araddr - nnPkg::ActBase) >> 2);
	assign rdByte = activations[rdIdx*8 +: 8];

	always_comb
	begin
		rdWord = '0;
		rdOk = 1'b1;
		if (isAct(araddr))
			rdWord = {{24{rdByte[7]}}, rdByte}; // sign-extended
		else
		begin
			case (araddr)
				nnPkg::CtrlAddr: rdWord = '0; // start bit self-clears
				nnPkg::StatusAddr: rdWord = {30'd0, done, busy || startPulse};
				nnPkg::ResultAddr: rdWord = resultReg;
				default: rdOk = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrReady <= 1'b0;
			bvalid <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
			startPulse <= 1'b0;
			done <= 1'b0;
			activations <= '0;
			resultReg <= '0;
		end
		else
		begin
			// free once the pending response drains
			wrReady <= !wrReady && awvalid && wvalid && (!bvalid || bready);
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wrFire)
				bvalid <= 1'b1;

			arready <= !arready && arvalid && (!rvalid || rready);
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (rdFire)
				rvalid <= 1'b1;

			if (wrFire && wrAct)
				activations[wrIdx*8 +: 8] <= wdata[7:0];
			startPulse <= wrStart;

			if (resultValid)
			begin
				resultReg <= results; // last item to finish wins
				done <= 1'b1;
			end
			if (wrStart)
				done <= 1'b0; // new item still in flight
		end
	end

	always_ff @(posedge clk)
	begin
		if (wrFire)
			bresp <= (wrAct || wrCtrl) ? nnPkg::RespOkay : nnPkg::RespSlvErr;
		if (rdFire)
		begin
			rdata <= rdWord;
			rresp <= rdOk ? nnPkg::RespOkay : nnPkg::RespSlvErr;
		end
	end

endmodule

/* src/nnAccelTop.sv */
`timescale 1ns/1ps

module nnAccelTop (
	input logic clk,
	input logic reset,
	input nnPkg::axiAddrT awaddr,
	input logic awvalid,
	output logic awready,
	input nnPkg::axiDataT wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output nnPkg::axiRespT bresp,
	output logic bvalid,
	input logic bready,
	input nnPkg::axiAddrT araddr,
	input logic arvalid,
	output logic arready,
	output nnPkg::axiDataT rdata,
	output nnPkg::axiRespT rresp,
	output logic rvalid,
	input logic rready
);

	nnPkg::actVecT activations;
	logic startPulse;
	nnPkg::resultVecT results;
	logic resultValid;
	logic busy;

	axiRegFile i_regFile (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.activations(activations),
		.startPulse(startPulse),
		.results(results),
		.resultValid(resultValid),
		.busy(busy)
	);

	denseLayer i_layer (
		.clk(clk),
		.reset(reset),
		.activations(activations),
		.inValid(startPulse),
		.results(results),
		.resultValid(resultValid),
		.busy(busy)
	);

endmodule

/* dv/nnAccelTb.sv */
`timescale 1ns/1ps

module nnAccelTb;

	localparam int MaxCycles = 6000; // ~60 inferences at up to 60 cycles plus margin

	logic clk;
	logic reset;
	nnPkg::axiAddrT awaddr;
	logic awvalid;
	logic awready;
	nnPkg::axiDataT wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	nnPkg::axiRespT bresp;
	logic bvalid;
	logic bready;
	nnPkg::axiAddrT araddr;
	logic arvalid;
	logic arready;
	nnPkg::axiDataT rdata;
	nnPkg::axiRespT rresp;
	logic rvalid;
	logic rready;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int k;
	logic [31:0] rngState = 32'd61;
	nnPkg::actVecT vecA;
	nnPkg::actVecT vecB;
	nnPkg::axiDataT rdBack;
	nnPkg::axiRespT respBack;
	logic [7:0] b;

	nnAccelTop i_dut (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MaxCycles)
		begin
			errors++;
			$display("Timeout: run did not finish within %0d cycles", MaxCycles);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("=== FAIL ===");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] randByte();
		rngState = xorshift32(rngState);
		return rngState[15:8];
	endfunction

	function automatic nnPkg::actVecT randVec();
		nnPkg::actVecT v;
		for (int i = 0; i < nnPkg::NumInputs; i++)
			v[8*i +: 8] = randByte();
		return v;
	endfunction

	// relu with saturation at 127 and 6 fraction bits rounded
	function automatic logic [7:0] nodeModel(input int node, input nnPkg::actVecT vec);
		int sum;
		int q;
		sum = nnPkg::BiasTable[node];
		for (int i = 0; i < nnPkg::NumInputs; i++)
			sum += $signed(vec[8*i +: 8]) * nnPkg::WeightTable[node][i];
		if (sum < 0)
			return 8'd0;
		if (sum >= 8192)
			return 8'd127;
		q = sum / 64;
		if (sum % 64 > 32)
			q = q + 1; // above one half
		return 8'(q);
	endfunction

	function automatic nnPkg::resultVecT packModel(input nnPkg::actVecT vec);
		nnPkg::resultVecT r;
		for (int n = 0; n < nnPkg::NumNodes; n++)
			r[8*n +: 8] = nodeModel(n, vec);
		return r;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("Mismatch at %0t: %s got 0x%08h, expected 0x%08h", $time, name, got, exp);
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			errors++;
			$display("Error at %0t: %s", $time, what);
		end
	endtask

	task automatic waitCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic axiWrite(input nnPkg::axiAddrT addr, input nnPkg::axiDataT data,
		output nnPkg::axiRespT resp);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		do
			waitCycle();
		while (!awready);
		checkTrue(wready === 1'b1, "wready did not rise together with awready");
		waitCycle(); // handshake edge
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid)
			waitCycle();
		resp = bresp;
		waitCycle(); // bready held high
	endtask

	task automatic axiRead(input nnPkg::axiAddrT addr, output nnPkg::axiDataT data,
		output nnPkg::axiRespT resp);
		araddr = addr;
		arvalid = 1'b1;
		do
			waitCycle();
		while (!arready);
		waitCycle();
		arvalid = 1'b0;
		while (!rvalid)
			waitCycle();
		data = rdata;
		resp = rresp;
		waitCycle();
	endtask

	task automatic writeExpect(input nnPkg::axiAddrT addr, input nnPkg::axiDataT data,
		input nnPkg::axiRespT exp);
		nnPkg::axiRespT resp;
		axiWrite(addr, data, resp);
		checkValue("bresp", resp, exp);
	endtask

	task automatic readExpect(input nnPkg::axiAddrT addr, input nnPkg::axiDataT expData,
		input nnPkg::axiRespT expResp, input string name);
		nnPkg::axiDataT data;
		nnPkg::axiRespT resp;
		axiRead(addr, data, resp);
		checkValue(name, data, expData);
		checkValue("rresp", resp, expResp);
	endtask

	task automatic loadActs(input nnPkg::actVecT vec);
		for (int i = 0; i < nnPkg::NumInputs; i++)
			writeExpect(8'(nnPkg::ActBase + 4 * i), {24'd0, vec[8*i +: 8]}, nnPkg::RespOkay);
	endtask

	task automatic startAndWait();
		nnPkg::axiDataT status;
		nnPkg::axiRespT resp;
		writeExpect(nnPkg::CtrlAddr, 32'd1, nnPkg::RespOkay);
		axiRead(nnPkg::StatusAddr, status, resp);
		checkTrue(status[1] == 1'b0, "done flag still set right after a start response");
		checkTrue(status[0] == 1'b1, "busy flag clear while an inference is in flight");
		while (!status[1])
			axiRead(nnPkg::StatusAddr, status, resp);
		checkTrue(status[0] == 1'b0, "busy flag still set after the inference completed");
	endtask

	initial
	begin
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hf;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		readExpect(nnPkg::StatusAddr, 32'd0, nnPkg::RespOkay, "rdata(status)");
		readExpect(nnPkg::ResultAddr, 32'd0, nnPkg::RespOkay, "rdata(result)");
		readExpect(8'h08, 32'd0, nnPkg::RespOkay, "rdata(act2)");

		// register readback with sign extension
		vecA = randVec();
		loadActs(vecA);
		for (int i = 0; i < nnPkg::NumInputs; i++)
		begin
			b = vecA[8*i +: 8];
			readExpect(8'(4 * i), {{24{b[7]}}, b}, nnPkg::RespOkay, "rdata(act)");
		end

		for (int t = 0; t < 50; t++)
		begin
			vecA = randVec();
			loadActs(vecA);
			startAndWait();
			readExpect(nnPkg::ResultAddr, packModel(vecA), nnPkg::RespOkay, "rdata(result)");
		end

		// each node driven to clamp, then to saturation
		for (int n = 0; n < nnPkg::NumNodes; n++)
		begin
			for (int s = 0; s < 2; s++)
			begin
				for (int i = 0; i < nnPkg::NumInputs; i++)
					vecA[8*i +: 8] = ((nnPkg::WeightTable[n][i] > 0) == (s == 1)) ? 8'h7f : 8'h80;
				checkValue("model node", nodeModel(n, vecA), s ? 8'd127 : 8'd0);
				loadActs(vecA);
				startAndWait();
				axiRead(nnPkg::ResultAddr, rdBack, respBack);
				checkValue("result node byte", rdBack[8*n +: 8], s ? 8'd127 : 8'd0);
				checkValue("rdata(result)", rdBack, packModel(vecA));
			end
		end

		// back to back with one byte changed for the second start
		vecA = randVec();
		loadActs(vecA);
		writeExpect(nnPkg::CtrlAddr, 32'd1, nnPkg::RespOkay);
		k = randByte() % nnPkg::NumInputs;
		vecB = vecA;
		vecB[8*k +: 8] = ~vecA[8*k +: 8];
		writeExpect(8'(4 * k), {24'd0, vecB[8*k +: 8]}, nnPkg::RespOkay);
		startAndWait();
		readExpect(nnPkg::ResultAddr, packModel(vecB), nnPkg::RespOkay, "rdata(result)");

		// error responses leave state alone
		writeExpect(8'h3c, 32'h5a, nnPkg::RespSlvErr);
		writeExpect(8'h4c, 32'h5a, nnPkg::RespSlvErr);
		writeExpect(8'h01, 32'h5a, nnPkg::RespSlvErr); // unaligned
		writeExpect(nnPkg::StatusAddr, 32'h3, nnPkg::RespSlvErr);
		writeExpect(nnPkg::ResultAddr, 32'hffff_ffff, nnPkg::RespSlvErr);
		readExpect(8'h3c, 32'd0, nnPkg::RespSlvErr, "rdata(unmapped)");
		readExpect(8'h4c, 32'd0, nnPkg::RespSlvErr, "rdata(unmapped)");
		readExpect(8'hfc, 32'd0, nnPkg::RespSlvErr, "rdata(unmapped)");
		for (int i = 0; i < nnPkg::NumInputs; i++)
		begin
			b = vecB[8*i +: 8];
			readExpect(8'(4 * i), {{24{b[7]}}, b}, nnPkg::RespOkay, "rdata(act)");
		end
		readExpect(nnPkg::ResultAddr, packModel(vecB), nnPkg::RespOkay, "rdata(result)");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* filelist.f */
common/nnPkg.sv
layer/neuronNode.sv
layer/denseLayer.sv
axiFront/axiRegFile.sv
src/nnAccelTop.sv
dv/nnAccelTb.sv

/* Bender.yml */
package:
  name: nn_accel

sources:
  - files:
      - common/nnPkg.sv
      - layer/neuronNode.sv
      - layer/denseLayer.sv
      - axiFront/axiRegFile.sv
      - src/nnAccelTop.sv
  - target: test
    files:
      - dv/nnAccelTb.sv
